/* sources.f */
design/rv_pkg.sv
design/inst_decoder.sv
design/int_alu.sv
design/reg_file.sv
design/hazard_unit.sv
design/pipeline_core.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/soc_top.sv
dv/arb_props.sv
dv/tb_soc.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_soc
RTL_TOP  = soc_top
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_soc.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_soc;
    import rv_pkg::*;

    localparam int ADDR_W       = 10;
    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 4;
    localparam int N_TESTS      = 5;
    localparam int TEST_CYCLES  = 200;

    // host request, same packed layout as the dut port
    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
    } host_req_t;

    logic      CLK;
    logic      RESET_N;
    logic      run;
    host_req_t host;
    word_t     host_rdata;
    wb_trace_t wb;

    logic [31:0] lfsr_state;
    wb_trace_t   trace_q[$];
    wb_trace_t   exp_q[$];
    word_t       prog_q[$];
    int          errors;
    int          checks;
    int          test_num;
    int          errs_before;

    soc_top #(.ADDR_W(ADDR_W)) dut0 (
        .CLK(CLK), .RESET_N(RESET_N), .run(run),
        .host(host), .host_rdata(host_rdata), .wb(wb)
    );

    always #(PERIOD/2) CLK = ~CLK;

    // trace monitor, wb only moves on the rising edge
    always @(negedge CLK) begin
        if (wb.valid) begin
            trace_q.push_back(wb);
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // rv32i encodings
    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t addi(input logic [4:0] rd, input logic [4:0] rs1,
                                   input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t lw(input logic [4:0] rd, input logic [4:0] rs1,
                                 input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                 input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // f3 of 000 is beq, 001 is bne
    function automatic word_t branch(input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // beq x0,x0 to itself, end of every program
    function automatic word_t self_loop();
        return branch(3'b000, 5'd0, 5'd0, 13'd0);
    endfunction

    task automatic check_trace(input string name, input wb_trace_t exp, input wb_trace_t act);
        checks++;
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected rd=%0d data=%h, got rd=%0d data=%h",
                     $time, name, exp.rd, exp.data, act.rd, act.data);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_wb(input logic [4:0] rd, input word_t data);
        exp_q.push_back('{valid: 1'b1, rd: rd, data: data});
    endtask

    task automatic start_test();
        test_num++;
        errs_before = errors;
        trace_q.delete();
        exp_q.delete();
        prog_q.delete();
    endtask

    task automatic report_test(input string name);
        $display("test %0d %s: %0d errors", test_num, name, errors - errs_before);
    endtask

    // host port, a write lands on the next rising edge
    task automatic write_host(input logic [ADDR_W-1:0] addr, input word_t data);
        @(posedge CLK);
        #2;
        host = '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    endtask

    task automatic read_host(input logic [ADDR_W-1:0] addr, output word_t data);
        @(posedge CLK);
        #2;
        host = '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
        // combinational read, settled by the falling edge
        @(negedge CLK);
        data = host_rdata;
    endtask

    task automatic release_host();
        @(posedge CLK);
        #2;
        host = '0;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_q.size(); i++) begin
            write_host(ADDR_W'(i), prog_q[i]);
        end
        // zero words past the loop decode as no-ops
        write_host(ADDR_W'(prog_q.size()), '0);
        write_host(ADDR_W'(prog_q.size() + 1), '0);
    endtask

    task automatic compare_trace();
        if (trace_q.size() != exp_q.size()) begin
            $display("trace held %0d writebacks where %0d were expected",
                     trace_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < exp_q.size() && i < trace_q.size(); i++) begin
            check_trace($sformatf("wb[%0d]", i), exp_q[i], trace_q[i]);
        end
    endtask

    task automatic run_program();
        int cycles;
        cycles = 0;
        @(posedge CLK);
        #2;
        host = '0;
        run  = 1'b1;
        while (trace_q.size() < exp_q.size() && cycles < TEST_CYCLES) begin
            @(negedge CLK);
            cycles++;
        end
        if (trace_q.size() < exp_q.size()) begin
            $display("timed out with %0d of %0d writebacks seen",
                     trace_q.size(), exp_q.size());
            errors++;
        end
        // self loop retires nothing, extra entries would show here
        repeat (10) @(negedge CLK);
        @(posedge CLK);
        #2;
        run = 1'b0;
        @(posedge CLK);
        #2;
        compare_trace();
    endtask

    task automatic alu_chain_test();
        logic [11:0] imm1;
        logic [11:0] imm2;
        word_t       v [1:9];
        start_test();
        imm1 = 12'(rand_bits(12));
        imm2 = 12'(rand_bits(12));
        // every step reads the one before it
        prog_q.push_back(addi(5'd1, 5'd0, imm1));
        prog_q.push_back(addi(5'd2, 5'd1, imm2));
        prog_q.push_back(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        prog_q.push_back(r_type(7'h20, 3'b000, 5'd4, 5'd2, 5'd3));
        prog_q.push_back(r_type(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
        prog_q.push_back(r_type(7'h00, 3'b110, 5'd6, 5'd5, 5'd1));
        prog_q.push_back(r_type(7'h00, 3'b100, 5'd7, 5'd6, 5'd4));
        prog_q.push_back(r_type(7'h00, 3'b010, 5'd8, 5'd7, 5'd3));
        prog_q.push_back(r_type(7'h00, 3'b010, 5'd9, 5'd3, 5'd7));
        prog_q.push_back(self_loop());
        // sequential isa results
        v[1] = sext12(imm1);
        v[2] = v[1] + sext12(imm2);
        v[3] = v[1] + v[2];
        v[4] = v[2] - v[3];
        v[5] = v[4] & v[3];
        v[6] = v[5] | v[1];
        v[7] = v[6] ^ v[4];
        v[8] = ($signed(v[7]) < $signed(v[3])) ? 32'd1 : 32'd0;
        v[9] = ($signed(v[3]) < $signed(v[7])) ? 32'd1 : 32'd0;
        for (int i = 1; i <= 9; i++) begin
            expect_wb(5'(i), v[i]);
        end
        load_program();
        run_program();
        report_test("alu chain");
    endtask

    task automatic load_store_test();
        logic [19:0] hi;
        logic [11:0] lo;
        word_t       pre;
        word_t       st;
        word_t       got;
        start_test();
        hi  = 20'(rand_bits(20));
        lo  = 12'(rand_bits(12));
        pre = rand_bits(32);
        st  = {hi, 12'h000} + sext12(lo);
        // byte address 0x400 is word 256
        prog_q.push_back(addi(5'd10, 5'd0, 12'h400));
        prog_q.push_back(lui(5'd11, hi));
        prog_q.push_back(addi(5'd11, 5'd11, lo));
        prog_q.push_back(sw(5'd11, 5'd10, 12'h000));
        prog_q.push_back(lw(5'd12, 5'd10, 12'h000));
        prog_q.push_back(r_type(7'h00, 3'b000, 5'd13, 5'd12, 5'd12));
        prog_q.push_back(lw(5'd14, 5'd10, 12'h004));
        prog_q.push_back(self_loop());
        expect_wb(5'd10, 32'h0000_0400);
        expect_wb(5'd11, {hi, 12'h000});
        expect_wb(5'd11, st);
        expect_wb(5'd12, st);
        expect_wb(5'd13, st + st);
        expect_wb(5'd14, pre);
        load_program();
        write_host(ADDR_W'(256), '0);
        write_host(ADDR_W'(257), pre);
        run_program();
        read_host(ADDR_W'(256), got);
        check_word("mem[256]", st, got);
        release_host();
        report_test("load store");
    endtask

    task automatic branch_test();
        logic [11:0] a;
        start_test();
        a = 12'(rand_bits(12));
        prog_q.push_back(addi(5'd1, 5'd0, a));
        prog_q.push_back(addi(5'd2, 5'd0, a));
        // taken, skips x3 and x4
        prog_q.push_back(branch(3'b000, 5'd1, 5'd2, 13'd12));
        prog_q.push_back(addi(5'd3, 5'd0, 12'h111));
        prog_q.push_back(addi(5'd4, 5'd0, 12'h222));
        // not taken, falls through to x5 and x6
        prog_q.push_back(branch(3'b001, 5'd1, 5'd2, 13'd8));
        prog_q.push_back(addi(5'd5, 5'd0, 12'h333));
        prog_q.push_back(addi(5'd6, 5'd0, 12'h444));
        prog_q.push_back(self_loop());
        expect_wb(5'd1, sext12(a));
        expect_wb(5'd2, sext12(a));
        expect_wb(5'd5, 32'h0000_0333);
        expect_wb(5'd6, 32'h0000_0444);
        load_program();
        run_program();
        report_test("branches");
    endtask

    task automatic lui_x0_test();
        logic [19:0] u;
        start_test();
        u = 20'(rand_bits(20));
        prog_q.push_back(lui(5'd7, u));
        // write to x0 leaves no trace
        prog_q.push_back(addi(5'd0, 5'd0, 12'd77));
        prog_q.push_back(r_type(7'h00, 3'b000, 5'd8, 5'd0, 5'd0));
        prog_q.push_back(r_type(7'h00, 3'b000, 5'd9, 5'd7, 5'd0));
        prog_q.push_back(self_loop());
        expect_wb(5'd7, {u, 12'h000});
        expect_wb(5'd8, '0);
        expect_wb(5'd9, {u, 12'h000});
        load_program();
        run_program();
        report_test("lui and x0");
    endtask

    task automatic host_port_test();
        word_t words [16];
        word_t got;
        start_test();
        for (int i = 0; i < 16; i++) begin
            words[i] = rand_bits(32);
            write_host(ADDR_W'(600 + 3 * i), words[i]);
        end
        for (int i = 0; i < 16; i++) begin
            read_host(ADDR_W'(600 + 3 * i), got);
            check_word($sformatf("mem[%0d]", 600 + 3 * i), words[i], got);
        end
        release_host();
        // core idle the whole time
        if (trace_q.size() != 0) begin
            $display("%0d writebacks seen while run was low", trace_q.size());
            errors++;
        end
        report_test("host port");
    endtask

    initial begin
        CLK         = 1'b0;
        RESET_N     = 1'b0;
        run         = 1'b0;
        host        = '0;
        lfsr_state  = 32'h883e_1a67;
        errors      = 0;
        checks      = 0;
        test_num    = 0;
        errs_before = 0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        RESET_N = 1'b1;
        alu_chain_test();
        load_store_test();
        branch_test();
        lui_x0_test();
        host_port_test();
        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog, budget of TEST_CYCLES per test
    initial begin
        #((RESET_CYCLES + N_TESTS * TEST_CYCLES) * PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/arb_props.sv */
`timescale 1ns/10ps
`default_nettype none

module arb_props (
    input logic CLK,
    input logic RESET_N,
    input logic host_req,
    input logic data_req,
    input logic fetch_req,
    input logic host_gnt,
    input logic data_gnt,
    input logic fetch_gnt
);

    // single port, one winner per cycle
    a_one_grant: assert property (@(posedge CLK) disable iff (!RESET_N)
        $onehot0({host_gnt, data_gnt, fetch_gnt}))
        else $error("arbiter granted more than one requester");

    // grant only where a request stands
    a_gnt_has_req: assert property (@(posedge CLK) disable iff (!RESET_N)
        (!host_gnt || host_req) && (!data_gnt || data_req) && (!fetch_gnt || fetch_req))
        else $error("arbiter granted a requester that was not asking");

    // host at the top of the order
    a_host_wins: assert property (@(posedge CLK) disable iff (!RESET_N)
        host_req |-> host_gnt)
        else $error("host request went without a grant");

endmodule

// arbiter is combinational, clock comes from the enclosing top level
bind soc_top arb_props u_arb_props (
    .CLK(CLK),
    .RESET_N(RESET_N),
    .host_req(host.req),
    .data_req(data_req.req),
    .fetch_req(fetch_req.req),
    .host_gnt(u_arb.host_gnt),
    .data_gnt(data_gnt),
    .fetch_gnt(fetch_gnt)
);

`default_nettype wire

/* design/soc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_top #(
    parameter int ADDR_W = 10
) (
    CLK, RESET_N, run, host, host_rdata, wb
);
    import rv_pkg::*;

    // one memory port request, word addressed
    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
    } mem_req_t;

    input  logic              CLK;
    input  logic              RESET_N;
    input  logic              run;
    input  mem_req_t          host;
    output rv_pkg::word_t     host_rdata;
    output rv_pkg::wb_trace_t wb;

    mem_req_t fetch_req;
    mem_req_t data_req;
    mem_req_t mem_port;
    logic     fetch_gnt;
    logic     data_gnt;

    // memory read data fans out to host and core alike
    pipeline_core #(.ADDR_W(ADDR_W)) u_core (
        .CLK(CLK), .RESET_N(RESET_N), .run(run),
        .fetch_req(fetch_req), .data_req(data_req),
        .fetch_gnt(fetch_gnt), .data_gnt(data_gnt),
        .mem_rdata(host_rdata), .wb(wb)
    );

    // host always wins, so its grant stays internal
    mem_arbiter #(.ADDR_W(ADDR_W)) u_arb (
        .host(host), .data(data_req), .fetch(fetch_req),
        .host_gnt(), .data_gnt(data_gnt), .fetch_gnt(fetch_gnt),
        .mem(mem_port)
    );

    unified_mem #(.ADDR_W(ADDR_W)) u_mem (
        .CLK(CLK), .port(mem_port), .rdata(host_rdata)
    );

endmodule

`default_nettype wire

/* design/unified_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module unified_mem #(
    parameter int ADDR_W = 10
) (
    CLK, port, rdata
);
    import rv_pkg::*;

    // one memory port request, word addressed
    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
    } mem_req_t;

    input  logic          CLK;
    input  mem_req_t      port;
    output rv_pkg::word_t rdata;

    // instructions and data share this array
    word_t mem_array [2**ADDR_W];

    // read in the granted cycle
    assign rdata = mem_array[port.addr];

    always_ff @(posedge CLK) begin
        if (port.req && port.we) begin
            mem_array[port.addr] <= port.wdata;
        end
    end

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter #(
    parameter int ADDR_W = 10
) (
    host, data, fetch, host_gnt, data_gnt, fetch_gnt, mem
);
    import rv_pkg::*;

    // one memory port request, word addressed
    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
    } mem_req_t;

    input  mem_req_t host;
    input  mem_req_t data;
    input  mem_req_t fetch;
    output logic     host_gnt;
    output logic     data_gnt;
    output logic     fetch_gnt;
    output mem_req_t mem;

    // fixed order host, data, fetch
    assign host_gnt  = host.req;
    assign data_gnt  = data.req && !host.req;
    assign fetch_gnt = fetch.req && !host.req && !data.req;

    always_comb begin
        // idle port when nobody asks
        mem = '0;
        if (host_gnt) begin
            mem = host;
        end else if (data_gnt) begin
            mem = data;
        end else if (fetch_gnt) begin
            mem = fetch;
        end
    end

endmodule

`default_nettype wire

/* design/pipeline_core.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeline_core #(
    parameter int ADDR_W = 10
) (
    CLK, RESET_N, run, fetch_req, data_req, fetch_gnt, data_gnt, mem_rdata, wb
);
    import rv_pkg::*;

    // one word-addressed memory port request
    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
    } mem_req_t;

    input  logic              CLK;
    input  logic              RESET_N;
    input  logic              run;
    output mem_req_t          fetch_req;
    output mem_req_t          data_req;
    input  logic              fetch_gnt;
    input  logic              data_gnt;
    input  rv_pkg::word_t     mem_rdata;
    output rv_pkg::wb_trace_t wb;

    // fetched word and its pc
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    word_t      pc;
    if_id_t     if_id;
    id_ex_t     id_ex;
    ex_mem_t    ex_mem;
    mem_wb_t    mem_wb;
    ctrl_t      id_ctrl;
    word_t      id_imm;
    word_t      id_rdata1;
    word_t      id_rdata2;
    logic [4:0] id_rs1;
    logic [4:0] id_rs2;
    id_ex_t     id_next;
    ex_mem_t    ex_next;
    word_t      alu_b;
    word_t      alu_result;
    word_t      branch_target;
    logic       alu_zero;
    logic       branch_taken;
    logic       stall;
    logic       flush;
    logic       mem_stall;

    // bubbles in decode present no sources
    assign id_rs1 = if_id.valid ? if_id.inst[19:15] : 5'd0;
    assign id_rs2 = if_id.valid ? if_id.inst[24:20] : 5'd0;

    inst_decoder u_dec (.inst(if_id.inst), .ctrl(id_ctrl), .imm(id_imm));

    reg_file u_rf (
        .CLK(CLK), .RESET_N(RESET_N),
        .rs1(id_rs1), .rs2(id_rs2),
        .rd(mem_wb.rd), .wdata(mem_wb.data), .we(mem_wb.valid && mem_wb.reg_write),
        .rdata1(id_rdata1), .rdata2(id_rdata2)
    );

    hazard_unit u_haz (
        .id_rs1(id_rs1), .id_rs2(id_rs2), .id_ex(id_ex), .ex_mem(ex_mem),
        .branch_taken(branch_taken), .stall(stall), .flush(flush)
    );

    always_comb begin
        id_next = '{valid: if_id.valid, ctrl: id_ctrl, pc: if_id.pc,
                    rs1_val: id_rdata1, rs2_val: id_rdata2, imm: id_imm,
                    rs1: id_rs1, rs2: id_rs2, rd: if_id.inst[11:7]};
    end

    // branches compare through the alu in execute
    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_val;

    int_alu u_alu (.a(id_ex.rs1_val), .b(alu_b), .op(id_ex.ctrl.alu_op),
                   .result(alu_result), .zero(alu_zero));

    assign branch_target = id_ex.pc + id_ex.imm;
    assign branch_taken  = id_ex.valid && id_ex.ctrl.is_branch &&
                           (alu_zero != id_ex.ctrl.branch_ne);

    always_comb begin
        ex_next = '{valid: id_ex.valid, ctrl: id_ex.ctrl, alu_result: alu_result,
                    store_data: id_ex.rs2_val, rd: id_ex.rd};
    end

    // memory stage owns the data port and asks nothing while run is low
    always_comb begin
        data_req.req   = run && ex_mem.valid &&
                         (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);
        data_req.we    = ex_mem.valid && ex_mem.ctrl.mem_write;
        data_req.addr  = ex_mem.alu_result[ADDR_W+1:2];
        data_req.wdata = ex_mem.store_data;
    end

    // data access without grant freezes the whole pipe
    assign mem_stall = data_req.req && !data_gnt;

    // fetch asks in every running cycle
    // the granted word is only used when the pipe advances
    always_comb begin
        fetch_req.req   = run;
        fetch_req.we    = 1'b0;
        fetch_req.addr  = pc[ADDR_W+1:2];
        fetch_req.wdata = '0;
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc     <= '0;
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
        end else if (!run) begin
            // idle with pc parked at zero and the pipe empty
            pc     <= '0;
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
        end else if (!mem_stall) begin
            ex_mem <= ex_next;
            if (flush) begin
                // kill the two younger instructions
                pc          <= branch_target;
                if_id.valid <= 1'b0;
                id_ex.valid <= 1'b0;
            end else if (stall) begin
                // hold pc and if/id and send a bubble into execute
                id_ex.valid <= 1'b0;
            end else begin
                id_ex <= id_next;
                if (fetch_gnt) begin
                    pc    <= pc + 32'd4;
                    if_id <= '{valid: 1'b1, pc: pc, inst: mem_rdata};
                end else begin
                    if_id.valid <= 1'b0;
                end
            end
        end
    end

    // writeback register takes a bubble while memory waits
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid     <= run && ex_mem.valid && !mem_stall;
            mem_wb.reg_write <= ex_mem.ctrl.reg_write && ex_mem.rd != 5'd0;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.data      <= ex_mem.ctrl.mem_read ? mem_rdata : ex_mem.alu_result;
        end
    end

    // x0 writes never show on the retirement trace
    assign wb.valid = mem_wb.valid && mem_wb.reg_write;
    assign wb.rd    = mem_wb.rd;
    assign wb.data  = mem_wb.data;

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    input  logic            [4:0] id_rs1,
    input  logic            [4:0] id_rs2,
    input  rv_pkg::id_ex_t        id_ex,
    input  rv_pkg::ex_mem_t       ex_mem,
    input  logic                  branch_taken,
    output logic                  stall,
    output logic                  flush
);
    import rv_pkg::*;

    logic ex_hit;
    logic mem_hit;

    // pending write in execute, rd of zero never counts
    assign ex_hit = id_ex.valid && id_ex.ctrl.reg_write && id_ex.rd != 5'd0 &&
                    (id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

    // pending write in memory, loads included
    assign mem_hit = ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.rd != 5'd0 &&
                     (ex_mem.rd == id_rs1 || ex_mem.rd == id_rs2);

    // a taken branch kills the stalled instruction anyway
    assign flush = branch_taken;
    assign stall = (ex_hit || mem_hit) && !branch_taken;

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic          CLK,
    input  logic          RESET_N,
    input  logic [4:0]    rs1,
    input  logic [4:0]    rs2,
    input  logic [4:0]    rd,
    input  rv_pkg::word_t wdata,
    input  logic          we,
    output rv_pkg::word_t rdata1,
    output rv_pkg::word_t rdata2
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // write-first, so writeback reaches decode in the same cycle
    assign rdata1 = (rs1 == 5'd0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

/* design/int_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module int_alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::word_t   result,
    output logic            zero
);
    import rv_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            // signed compare, result is 0 or 1
            ALU_SLT: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_PASS_B: result = b;
            default: result = '0;
        endcase
    end

    // branch equality test
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* design/inst_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  rv_pkg::word_t inst,
    output rv_pkg::ctrl_t ctrl,
    output rv_pkg::word_t imm
);
    import rv_pkg::*;

    logic [2:0] funct3;
    logic       funct7_5;

    assign funct3   = inst[14:12];
    assign funct7_5 = inst[30];

    always_comb begin
        // unknown encodings fall out as a no-op
        ctrl = '0;
        imm  = '0;
        case (opcode_e'(inst[6:0]))
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = funct7_5 ? ALU_SUB : ALU_ADD;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b111: ctrl.alu_op = ALU_AND;
                    default: ctrl = '0;
                endcase
            end
            OPC_OP_IMM: begin
                // only addi in the subset
                if (funct3 == 3'b000) begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = ALU_ADD;
                end
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            OPC_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_PASS_B;
                imm = {inst[31:12], 12'b0};
            end
            OPC_LOAD: begin
                // word access only
                if (funct3 == 3'b010) begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = ALU_ADD;
                end
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = ALU_ADD;
                end
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OPC_BRANCH: begin
                // beq and bne compare through subtraction
                if (funct3[2:1] == 2'b00) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.branch_ne = funct3[0];
                    ctrl.alu_op    = ALU_SUB;
                end
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // data word width
    localparam int xlen = 32;

    // data field of one memory port request
    typedef logic [xlen-1:0] word_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // alu selection, pass_b carries the lui immediate through
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // control bundle from decode
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    is_branch;
        logic    branch_ne;
        alu_op_e alu_op;
    } ctrl_t;

    // decode to execute
    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        word_t      pc;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      imm;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        word_t      alu_result;
        word_t      store_data;
        logic [4:0] rd;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic       valid;
        logic       reg_write;
        logic [4:0] rd;
        word_t      data;
    } mem_wb_t;

    // retirement trace seen at the top level
    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        word_t      data;
    } wb_trace_t;

endpackage

`default_nettype wire
